// ==== design/rgb_cap_params.svh ====
`ifndef RGB_CAP_PARAMS_SVH
`define RGB_CAP_PARAMS_SVH

// Pixel format of the single colour channel
`define RGB_PIX_W 4

// RAM word and packing
`define RGB_WORD_W 16
`define RGB_PIX_PER_WORD 4

// One stored frame, 32 pixels
`define RGB_FRAME_WORDS 8

// Enough bits to address every frame word
`define RGB_ADDR_W 3

`endif

// ==== design/rgb_cap_pkg.sv ====
`include "rgb_cap_params.svh"

package rgb_cap_pkg;

    //////////////////////////////////////////////////
    // Data types shared by the capture and replay paths
    //////////////////////////////////////////////////

    typedef logic [`RGB_PIX_W-1:0] pixel_t;

    // First pixel of a group sits in the lowest nibble
    typedef logic [`RGB_WORD_W-1:0] word_t;

    typedef logic [`RGB_ADDR_W-1:0] addr_t;

    // Capture control states
    typedef enum logic [1:0] {
        CAP_ARMED = 2'd0,
        CAP_RUN   = 2'd1,
        CAP_DONE  = 2'd2
    } cap_state_t;

endpackage

// ==== design/capture_ctrl.sv ====
`timescale 1ns/1ps
`include "rgb_cap_params.svh"

module capture_ctrl (
    input  logic                disp_clk,
    input  logic                nrst,
    input  logic                vsync,
    input  logic                capture_start,
    input  logic                wr_en,
    input  rgb_cap_pkg::addr_t  wr_addr,
    output logic                cap_en,
    output logic                stream_ready
);

    localparam rgb_cap_pkg::addr_t LAST_ADDR = rgb_cap_pkg::addr_t'(`RGB_FRAME_WORDS - 1);

    rgb_cap_pkg::cap_state_t state;
    rgb_cap_pkg::cap_state_t state_nxt;
    logic                    vsync_d;
    logic                    vsync_rise;
    logic                    last_write;

    // Frame start marker
    assign vsync_rise = vsync & ~vsync_d;

    // Last word of the frame goes to RAM this cycle
    assign last_write = wr_en && (wr_addr == LAST_ADDR);

    always_ff @(posedge disp_clk or negedge nrst) begin
        if (!nrst) begin
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= vsync;
        end
    end

    //////////////////////////////////////////////////
    // Capture FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        if (capture_start) begin
            // Re-arm from any state
            state_nxt = rgb_cap_pkg::CAP_ARMED;
        end else begin
            case (state)
                rgb_cap_pkg::CAP_ARMED: if (vsync_rise) state_nxt = rgb_cap_pkg::CAP_RUN;
                rgb_cap_pkg::CAP_RUN:   if (last_write) state_nxt = rgb_cap_pkg::CAP_DONE;
                rgb_cap_pkg::CAP_DONE:  state_nxt = rgb_cap_pkg::CAP_DONE;
                default:                state_nxt = rgb_cap_pkg::CAP_ARMED;
            endcase
        end
    end

    always_ff @(posedge disp_clk or negedge nrst) begin
        if (!nrst) begin
            state <= rgb_cap_pkg::CAP_ARMED;
        end else begin
            state <= state_nxt;
        end
    end

    // Decoded outputs
    assign cap_en       = (state == rgb_cap_pkg::CAP_RUN);
    assign stream_ready = (state == rgb_cap_pkg::CAP_DONE);

endmodule

// ==== design/rgb_logic.sv ====
`timescale 1ns/1ps
`include "rgb_cap_params.svh"

module rgb_logic (
    input  logic                disp_clk,
    input  logic                nrst,
    input  rgb_cap_pkg::pixel_t pix_in,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                cap_en,
    output logic                wr_en,
    output rgb_cap_pkg::addr_t  wr_addr,
    output rgb_cap_pkg::word_t  wr_data
);

    localparam int POS_W = $clog2(`RGB_PIX_PER_WORD);
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(`RGB_PIX_PER_WORD - 1);
    // Nibbles held before the word completes
    localparam int BUF_W = `RGB_WORD_W - `RGB_PIX_W;

    logic             active;
    logic [POS_W-1:0] pack_pos;
    logic [BUF_W-1:0] pix_buf;

    // Visible pixel only while both syncs are high
    assign active = hsync & vsync;

    //////////////////////////////////////////////////
    // Word assembly
    //////////////////////////////////////////////////

    // Older pixels move toward the low end, so the first one ends in nibble 0
    always_ff @(posedge disp_clk) begin
        if (active) begin
            pix_buf <= {pix_in, pix_buf[BUF_W-1:`RGB_PIX_W]};
        end
    end

    // Fourth pixel completes the word on the same cycle it is sampled
    assign wr_data = {pix_in, pix_buf};
    assign wr_en   = cap_en & active & (pack_pos == LAST_POS);

    //////////////////////////////////////////////////
    // Pack position and write address
    //////////////////////////////////////////////////

    always_ff @(posedge disp_clk or negedge nrst) begin
        if (!nrst) begin
            pack_pos <= '0;
            wr_addr  <= '0;
        end else if (!cap_en) begin
            // Idle between captures
            pack_pos <= '0;
            wr_addr  <= '0;
        end else if (active) begin
            pack_pos <= pack_pos + 1'b1;
            if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

endmodule

// ==== design/ram.sv ====
`timescale 1ns/1ps
`include "rgb_cap_params.svh"

module ram (
    input  logic               disp_clk,
    input  logic               wr_en,
    input  rgb_cap_pkg::addr_t wr_addr,
    input  rgb_cap_pkg::word_t wr_data,
    input  rgb_cap_pkg::addr_t rd_addr,
    output rgb_cap_pkg::word_t rd_data
);

    // One frame of packed pixels
    rgb_cap_pkg::word_t mem [0:`RGB_FRAME_WORDS-1];

    // Synchronous write port
    always_ff @(posedge disp_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, old data on a same-address collision
    always_ff @(posedge disp_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== design/vga_dumper.sv ====
`timescale 1ns/1ps
`include "rgb_cap_params.svh"

module vga_dumper (
    input  logic                disp_clk,
    input  logic                nrst,
    input  rgb_cap_pkg::pixel_t pix_in,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                mode_ram,
    input  logic                stream_ready,
    output rgb_cap_pkg::addr_t  rd_addr,
    input  rgb_cap_pkg::word_t  rd_data,
    output rgb_cap_pkg::pixel_t vga_pix,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_blank_n
);

    localparam int SEL_W = $clog2(`RGB_PIX_PER_WORD);
    localparam int IDX_W = `RGB_ADDR_W + SEL_W;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`RGB_FRAME_WORDS * `RGB_PIX_PER_WORD - 1);

    logic [IDX_W-1:0]    pix_idx;
    logic                active;
    logic                replay;
    logic                hs_d;
    logic                vs_d;
    logic                act_d;
    logic                replay_d;
    logic [SEL_W-1:0]    nib_sel_d;
    rgb_cap_pkg::pixel_t pix_d;

    assign active  = hsync & vsync;
    // Stored frame shown only once one exists
    assign replay  = mode_ram & stream_ready;
    assign rd_addr = pix_idx[IDX_W-1:SEL_W];

    //////////////////////////////////////////////////
    // Replay pixel index
    //////////////////////////////////////////////////

    always_ff @(posedge disp_clk or negedge nrst) begin
        if (!nrst) begin
            pix_idx <= '0;
        end else if (vsync & ~vs_d) begin
            pix_idx <= '0;
        end else if (active && replay) begin
            pix_idx <= (pix_idx == LAST_IDX) ? '0 : pix_idx + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Stage 1, aligned with the RAM read
    //////////////////////////////////////////////////

    always_ff @(posedge disp_clk or negedge nrst) begin
        if (!nrst) begin
            hs_d      <= 1'b0;
            vs_d      <= 1'b0;
            act_d     <= 1'b0;
            replay_d  <= 1'b0;
            nib_sel_d <= '0;
            pix_d     <= '0;
        end else begin
            hs_d      <= hsync;
            vs_d      <= vsync;
            act_d     <= active;
            replay_d  <= replay;
            nib_sel_d <= pix_idx[SEL_W-1:0];
            pix_d     <= pix_in;
        end
    end

    // Stage 2, VGA output registers
    always_ff @(posedge disp_clk or negedge nrst) begin
        if (!nrst) begin
            vga_pix     <= '0;
            vga_hs      <= 1'b0;
            vga_vs      <= 1'b0;
            vga_blank_n <= 1'b0;
        end else begin
            vga_pix     <= replay_d ? rd_data[nib_sel_d*`RGB_PIX_W +: `RGB_PIX_W] : pix_d;
            vga_hs      <= hs_d;
            vga_vs      <= vs_d;
            vga_blank_n <= act_d;
        end
    end

endmodule

// ==== design/rgb_capture_top.sv ====
`timescale 1ns/1ps

module rgb_capture_top (
    input  logic                disp_clk,
    input  logic                nrst,
    input  rgb_cap_pkg::pixel_t pix_in,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                mode_ram,
    input  logic                capture_start,
    output rgb_cap_pkg::pixel_t vga_pix,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_blank_n,
    output logic                stream_ready
);

    logic               cap_en;
    logic               wr_en;
    rgb_cap_pkg::addr_t wr_addr;
    rgb_cap_pkg::word_t wr_data;
    rgb_cap_pkg::addr_t rd_addr;
    rgb_cap_pkg::word_t rd_data;

    //////////////////////////////////////////////////
    // Capture side
    //////////////////////////////////////////////////

    capture_ctrl u_ctrl (
        .disp_clk      (disp_clk),
        .nrst          (nrst),
        .vsync         (vsync),
        .capture_start (capture_start),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .cap_en        (cap_en),
        .stream_ready  (stream_ready)
    );

    rgb_logic u_rgb (
        .disp_clk (disp_clk),
        .nrst     (nrst),
        .pix_in   (pix_in),
        .hsync    (hsync),
        .vsync    (vsync),
        .cap_en   (cap_en),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // Frame store between the two clock-aligned paths
    ram u_ram (
        .disp_clk (disp_clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // Replay side and VGA port
    vga_dumper u_vga (
        .disp_clk     (disp_clk),
        .nrst         (nrst),
        .pix_in       (pix_in),
        .hsync        (hsync),
        .vsync        (vsync),
        .mode_ram     (mode_ram),
        .stream_ready (stream_ready),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .vga_pix      (vga_pix),
        .vga_hs       (vga_hs),
        .vga_vs       (vga_vs),
        .vga_blank_n  (vga_blank_n)
    );

endmodule

// ==== dv/rgb_capture_checker.sv ====
`timescale 1ns/1ps
`include "rgb_cap_params.svh"

module rgb_capture_checker (
    input logic               disp_clk,
    input logic               nrst,
    input logic               vsync,
    input logic               capture_start,
    input logic               wr_en,
    input rgb_cap_pkg::addr_t wr_addr,
    input logic               cap_en,
    input logic               stream_ready
);

    localparam rgb_cap_pkg::addr_t LAST_ADDR = rgb_cap_pkg::addr_t'(`RGB_FRAME_WORDS - 1);

    int fail_count;

    initial fail_count = 0;

    // A stored frame always ends with the write of its last word
    a_ready_after_last_write: assert property (@(posedge disp_clk) disable iff (!nrst)
        $rose(stream_ready) |-> $past(wr_en && wr_addr == LAST_ADDR))
        else begin
            fail_count++;
            $error("stream_ready rose without a write to the last frame address");
        end

    // A capture only starts from a vsync rising edge
    a_run_after_vsync_rise: assert property (@(posedge disp_clk) disable iff (!nrst)
        $rose(cap_en) |-> $past(vsync) && !$past(vsync, 2))
        else begin
            fail_count++;
            $error("cap_en rose without a preceding vsync rising edge");
        end

    a_start_clears_ready: assert property (@(posedge disp_clk) disable iff (!nrst)
        capture_start |=> !stream_ready)
        else begin
            fail_count++;
            $error("stream_ready is still high after a capture_start pulse");
        end

endmodule

bind capture_ctrl rgb_capture_checker u_checker (
    .disp_clk      (disp_clk),
    .nrst          (nrst),
    .vsync         (vsync),
    .capture_start (capture_start),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .cap_en        (cap_en),
    .stream_ready  (stream_ready)
);

// ==== dv/rgb_capture_monitor.sv ====
`timescale 1ns/1ps
`include "rgb_cap_params.svh"

module rgb_capture_monitor (
    input  logic                disp_clk,
    input  logic                nrst,
    input  rgb_cap_pkg::pixel_t pix_in,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                mode_ram,
    input  logic                capture_start,
    input  rgb_cap_pkg::pixel_t vga_pix,
    input  logic                vga_hs,
    input  logic                vga_vs,
    input  logic                vga_blank_n,
    input  logic                stream_ready,
    output int                  err_count
);

    localparam int FRAME_PIX = `RGB_FRAME_WORDS * `RGB_PIX_PER_WORD;
    localparam int IDX_W     = $clog2(FRAME_PIX);
    localparam logic [IDX_W-1:0] LAST_PIX = IDX_W'(FRAME_PIX - 1);
    localparam int EXP_W     = `RGB_PIX_W + 3;

    // Expected content of the stored frame, one entry per pixel
    rgb_cap_pkg::pixel_t     frame [0:FRAME_PIX-1];
    rgb_cap_pkg::cap_state_t model_state;
    logic [IDX_W-1:0]        cap_cnt;
    logic [IDX_W-1:0]        play_idx;
    logic                    vs_prev;
    logic                    rst_seen;
    // {pixel, hs, vs, blank_n} predicted per input cycle
    logic [EXP_W-1:0]        exp_q1;
    logic [EXP_W-1:0]        exp_q2;

    initial err_count = 0;
    initial rst_seen = 1'b0;

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %0b actual %0b", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_pix(input string name, input rgb_cap_pkg::pixel_t expected,
                             input rgb_cap_pkg::pixel_t actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    always @(posedge disp_clk) begin
        logic                active_now;
        logic                replay_now;
        rgb_cap_pkg::pixel_t exp_pix;
        if (!nrst) begin
            // Registers hold their reset values from the second reset edge on
            if (rst_seen) begin
                check_pix("vga_pix", '0, vga_pix);
                check_bit("vga_hs", 1'b0, vga_hs);
                check_bit("vga_vs", 1'b0, vga_vs);
                check_bit("vga_blank_n", 1'b0, vga_blank_n);
                check_bit("stream_ready", 1'b0, stream_ready);
            end
            rst_seen     = 1'b1;
            model_state <= rgb_cap_pkg::CAP_ARMED;
            cap_cnt     <= '0;
            play_idx    <= '0;
            vs_prev     <= 1'b0;
            exp_q1      <= '0;
            exp_q2      <= '0;
        end else begin
            // Outputs show the input cycle two edges back
            check_pix("vga_pix", exp_q2[EXP_W-1:3], vga_pix);
            check_bit("vga_hs", exp_q2[2], vga_hs);
            check_bit("vga_vs", exp_q2[1], vga_vs);
            check_bit("vga_blank_n", exp_q2[0], vga_blank_n);
            check_bit("stream_ready", model_state == rgb_cap_pkg::CAP_DONE, stream_ready);

            active_now = hsync & vsync;
            replay_now = mode_ram & (model_state == rgb_cap_pkg::CAP_DONE);
            exp_pix    = replay_now ? frame[play_idx] : pix_in;
            exp_q1     <= {exp_pix, hsync, vsync, active_now};
            exp_q2     <= exp_q1;

            // Capture rule at pixel level
            case (model_state)
                rgb_cap_pkg::CAP_ARMED: begin
                    cap_cnt <= '0;
                    if (vsync && !vs_prev) begin
                        model_state <= rgb_cap_pkg::CAP_RUN;
                    end
                end
                rgb_cap_pkg::CAP_RUN: begin
                    if (active_now) begin
                        frame[cap_cnt] <= pix_in;
                        cap_cnt        <= cap_cnt + 1'b1;
                        if (cap_cnt == LAST_PIX) begin
                            model_state <= rgb_cap_pkg::CAP_DONE;
                        end
                    end
                end
                default: cap_cnt <= '0;
            endcase
            if (capture_start) begin
                model_state <= rgb_cap_pkg::CAP_ARMED;
            end

            // Replay position restarts with each frame
            if (vsync && !vs_prev) begin
                play_idx <= '0;
            end else if (active_now && replay_now) begin
                play_idx <= (play_idx == LAST_PIX) ? '0 : play_idx + 1'b1;
            end
            vs_prev <= vsync;
        end
    end

endmodule

// ==== dv/tb_rgb_capture.sv ====
`timescale 1ns/1ps

module tb_rgb_capture;

    localparam int    CLK_HALF      = 2;
    localparam int    CLK_PERIOD    = 2 * CLK_HALF;
    localparam int    RST_CYCLES    = 3;
    localparam int    MARGIN_CYCLES = 100;
    localparam int    LINE_PIX      = 4;
    localparam int    LINE_BLANK    = 2;
    localparam string TRACE_FILE    = "dv/rgb_capture_trace.txt";

    logic                disp_clk;
    logic                nrst;
    rgb_cap_pkg::pixel_t pix_in;
    logic                hsync;
    logic                vsync;
    logic                mode_ram;
    logic                capture_start;
    rgb_cap_pkg::pixel_t vga_pix;
    logic                vga_hs;
    logic                vga_vs;
    logic                vga_blank_n;
    logic                stream_ready;

    int monitor_errors;
    int trace_errors;
    int timeout_errors;
    int seed;
    int watchdog_ns;

    // One entry per trace command
    string cmd_q[$];
    int    mode_q[$];
    int    count_q[$];
    int    ready_q[$];

    always #CLK_HALF disp_clk = ~disp_clk;

    rgb_capture_top uut (
        .disp_clk      (disp_clk),
        .nrst          (nrst),
        .pix_in        (pix_in),
        .hsync         (hsync),
        .vsync         (vsync),
        .mode_ram      (mode_ram),
        .capture_start (capture_start),
        .vga_pix       (vga_pix),
        .vga_hs        (vga_hs),
        .vga_vs        (vga_vs),
        .vga_blank_n   (vga_blank_n),
        .stream_ready  (stream_ready)
    );

    rgb_capture_monitor u_mon (
        .disp_clk      (disp_clk),
        .nrst          (nrst),
        .pix_in        (pix_in),
        .hsync         (hsync),
        .vsync         (vsync),
        .mode_ram      (mode_ram),
        .capture_start (capture_start),
        .vga_pix       (vga_pix),
        .vga_hs        (vga_hs),
        .vga_vs        (vga_vs),
        .vga_blank_n   (vga_blank_n),
        .stream_ready  (stream_ready),
        .err_count     (monitor_errors)
    );

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Inputs change on the falling edge only
    task automatic drive_cycle(input logic hs, input logic vs, input logic mode,
                               input logic start, input rgb_cap_pkg::pixel_t pix);
        @(negedge disp_clk);
        hsync         = hs;
        vsync         = vs;
        mode_ram      = mode;
        capture_start = start;
        pix_in        = pix;
    endtask

    task automatic next_pixel(output rgb_cap_pkg::pixel_t pix);
        int r;
        r   = $random(seed);
        pix = rgb_cap_pkg::pixel_t'(r);
    endtask

    // Vsync low, rise, two blank cycles, then the active lines
    task automatic send_frame(input logic mode, input int lines);
        rgb_cap_pkg::pixel_t pix;
        drive_cycle(1'b0, 1'b0, mode, 1'b0, '0);
        repeat (2) drive_cycle(1'b0, 1'b1, mode, 1'b0, '0);
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < LINE_PIX; p++) begin
                next_pixel(pix);
                drive_cycle(1'b1, 1'b1, mode, 1'b0, pix);
            end
            repeat (LINE_BLANK) drive_cycle(1'b0, 1'b1, mode, 1'b0, '0);
        end
    endtask

    function automatic int command_cycles(input string cmd, input int count);
        if (cmd == "FRAME") begin
            return 3 + count * (LINE_PIX + LINE_BLANK);
        end else if (cmd == "START") begin
            return 1;
        end else if (cmd == "IDLE") begin
            return count;
        end
        return 0;
    endfunction

    //////////////////////////////////////////////////
    // Trace handling
    //////////////////////////////////////////////////

    task automatic load_trace();
        int               fd;
        int               n;
        int               mode;
        int               cnt;
        int               rdy;
        string            cmd;
        logic [8*100-1:0] line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Error: cannot open trace file %s", TRACE_FILE);
            trace_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    // Header and blank lines do not parse to four fields
                    n = $sscanf(line, "%s %d %d %d", cmd, mode, cnt, rdy);
                    if (n == 4) begin
                        cmd_q.push_back(cmd);
                        mode_q.push_back(mode);
                        count_q.push_back(cnt);
                        ready_q.push_back(rdy);
                    end
                end
            end
            $fclose(fd);
            if (cmd_q.size() == 0) begin
                $display("Error: trace file holds no commands");
                trace_errors++;
            end
        end
    endtask

    task automatic run_command(input int i);
        logic mode;
        logic exp_ready;
        mode      = (mode_q[i] != 0);
        exp_ready = (ready_q[i] != 0);
        if (cmd_q[i] == "FRAME") begin
            send_frame(mode, count_q[i]);
        end else if (cmd_q[i] == "START") begin
            drive_cycle(1'b0, 1'b0, mode, 1'b1, '0);
        end else if (cmd_q[i] == "IDLE") begin
            repeat (count_q[i]) drive_cycle(1'b0, 1'b0, mode, 1'b0, '0);
        end else begin
            $display("Error: unknown trace command %s in entry %0d", cmd_q[i], i);
            trace_errors++;
        end
        // Settled value after the last driven cycle
        @(posedge disp_clk);
        #1;
        if (stream_ready !== exp_ready) begin
            $display("[FAIL] t=%0t stream_ready expected %0b actual %0b (trace entry %0d %s)",
                     $time, exp_ready, stream_ready, i, cmd_q[i]);
            trace_errors++;
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        int total;
        assert_errors = uut.u_ctrl.u_checker.fail_count;
        total         = monitor_errors + trace_errors + timeout_errors + assert_errors;
        $display("Error counts: monitor %0d, trace %0d, timeout %0d, assertion %0d",
                 monitor_errors, trace_errors, timeout_errors, assert_errors);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        int total_cycles;
        disp_clk       = 1'b0;
        nrst           = 1'b0;
        pix_in         = '0;
        hsync          = 1'b0;
        vsync          = 1'b0;
        mode_ram       = 1'b0;
        capture_start  = 1'b0;
        seed           = 32'hd72a_2e40;
        trace_errors   = 0;
        timeout_errors = 0;
        load_trace();
        total_cycles = RST_CYCLES + MARGIN_CYCLES;
        foreach (cmd_q[i]) begin
            total_cycles += command_cycles(cmd_q[i], count_q[i]);
        end
        watchdog_ns = total_cycles * CLK_PERIOD;
        repeat (RST_CYCLES) @(posedge disp_clk);
        @(negedge disp_clk);
        nrst = 1'b1;
        foreach (cmd_q[i]) begin
            run_command(i);
        end
        finish_run();
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout: the trace did not finish within %0d ns", watchdog_ns);
        timeout_errors++;
        finish_run();
    end

endmodule

// ==== dv/rgb_capture_trace.txt ====
# command  mode_ram  count  stream_ready at end of command
# count is active lines for FRAME and cycles for START and IDLE
IDLE   0  4  0
FRAME  0  8  1
FRAME  1  8  1
FRAME  1  8  1
IDLE   1  3  1
FRAME  0  8  1
FRAME  1  8  1
START  1  1  0
IDLE   1  2  0
FRAME  1  8  1
FRAME  1  8  1
FRAME  0  8  1
START  0  1  0
FRAME  0  4  0
FRAME  1  8  1
FRAME  1  8  1
IDLE   0  4  1

// ==== flist.f ====
+incdir+design
design/rgb_cap_pkg.sv
design/capture_ctrl.sv
design/rgb_logic.sv
design/ram.sv
design/vga_dumper.sv
design/rgb_capture_top.sv
dv/rgb_capture_checker.sv
dv/rgb_capture_monitor.sv
dv/tb_rgb_capture.sv

// ==== Makefile ====
TOP := tb_rgb_capture

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o $(TOP)

# Passes only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
